//--- src/plot_geom_pkg.sv
`default_nettype none

package plot_geom_pkg;

    // screen coordinates span 0 to 255 on both axes
    localparam int COORD_W = 8;

    typedef struct packed {
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
    } point_t;

    // tag is 4 bits, same width as the segment tag
    typedef struct packed {
        point_t     pt;
        logic [3:0] tag;
    } pixel_t;

endpackage

`default_nettype wire

//--- src/plot_cmd_pkg.sv
`default_nettype none

package plot_cmd_pkg;

    localparam int TAG_W = 4;

    // number of line rasterizers working in parallel
    localparam int N_RASTER = 3;
    localparam int RASTER_IDX_W = $clog2(N_RASTER);

    typedef logic [RASTER_IDX_W-1:0] raster_idx_t;

    typedef enum logic {
        MOVE = 1'b0,
        LINE = 1'b1
    } opcode_e;

    typedef struct packed {
        opcode_e               op;
        plot_geom_pkg::point_t target;
    } cmd_t;

    typedef struct packed {
        plot_geom_pkg::point_t start_pt;
        plot_geom_pkg::point_t end_pt;
        logic [TAG_W-1:0]      tag;
    } segment_t;

endpackage

`default_nettype wire

//--- src/segment_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module segment_dispatch (
    input  logic                                clk,
    input  logic                                rst,
    input  plot_cmd_pkg::cmd_t                  cmd,
    input  logic                                cmd_valid,
    output logic                                cmd_ready,
    output plot_cmd_pkg::segment_t              seg,
    output logic [plot_cmd_pkg::N_RASTER-1:0]   seg_valid,
    input  logic [plot_cmd_pkg::N_RASTER-1:0]   seg_ready,
    output logic                                pending
);

    plot_geom_pkg::point_t          cursor;
    logic [plot_cmd_pkg::TAG_W-1:0] tag;
    plot_cmd_pkg::segment_t         pend_seg;
    logic                           cmd_fire;
    logic                           line_fire;
    logic                           seg_fire;
    logic                           pick_found;

    // a held LINE blocks further commands until a rasterizer takes it
    assign cmd_ready = !pending;
    assign cmd_fire  = cmd_valid && cmd_ready;
    assign line_fire = cmd_fire && (cmd.op == plot_cmd_pkg::LINE);
    assign seg_fire  = |(seg_valid & seg_ready);
    assign seg       = pend_seg;

    // offer the pending segment to the lowest numbered idle rasterizer
    always_comb begin
        pick_found = 1'b0;
        seg_valid  = '0;
        for (int k = 0; k < plot_cmd_pkg::N_RASTER; k++) begin
            if (!pick_found && seg_ready[k]) begin
                seg_valid[k] = pending;
                pick_found   = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cursor  <= '0;
            tag     <= '0;
            pending <= 1'b0;
        end else begin
            if (seg_fire) begin
                pending <= 1'b0;
            end
            // both opcodes leave the cursor at their target
            if (cmd_fire) begin
                cursor <= cmd.target;
            end
            if (line_fire) begin
                pending <= 1'b1;
                tag     <= tag + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line_fire) begin
            pend_seg.start_pt <= cursor;
            pend_seg.end_pt   <= cmd.target;
            pend_seg.tag      <= tag;
        end
    end

endmodule

`default_nettype wire

//--- src/line_raster.sv
`timescale 1ns/1ps
`default_nettype none

module line_raster (
    input  logic                   clk,
    input  logic                   rst,
    input  plot_cmd_pkg::segment_t seg,
    input  logic                   seg_valid,
    output logic                   seg_ready,
    output plot_geom_pkg::pixel_t  pix,
    output logic                   pix_valid,
    input  logic                   pix_ready
);

    typedef enum logic {
        IDLE,
        WALK
    } state_e;

    state_e                                   state;
    plot_geom_pkg::point_t                    cur;
    plot_geom_pkg::point_t                    last;
    logic [plot_cmd_pkg::TAG_W-1:0]           tag;
    logic signed [plot_geom_pkg::COORD_W+1:0] dx;
    logic signed [plot_geom_pkg::COORD_W+1:0] dy;
    logic signed [plot_geom_pkg::COORD_W+1:0] err;
    logic                                     sx;
    logic                                     sy;

    // segment setup terms
    logic signed [plot_geom_pkg::COORD_W+1:0] diff_x;
    logic signed [plot_geom_pkg::COORD_W+1:0] diff_y;
    logic signed [plot_geom_pkg::COORD_W+1:0] init_dx;
    logic signed [plot_geom_pkg::COORD_W+1:0] init_dy;

    // one Bresenham step
    logic signed [plot_geom_pkg::COORD_W+2:0] e2;
    logic signed [plot_geom_pkg::COORD_W+1:0] err_nxt;
    plot_geom_pkg::point_t                    cur_nxt;

    logic seg_fire;
    logic at_end;

    assign seg_ready = (state == IDLE);
    assign pix_valid = (state == WALK);
    assign pix.pt    = cur;
    assign pix.tag   = tag;
    assign seg_fire  = seg_valid && seg_ready;
    assign at_end    = (cur == last);

    always_comb begin
        diff_x  = $signed({2'b00, seg.end_pt.x}) - $signed({2'b00, seg.start_pt.x});
        diff_y  = $signed({2'b00, seg.end_pt.y}) - $signed({2'b00, seg.start_pt.y});
        // dx is kept positive, dy negative
        init_dx = diff_x[plot_geom_pkg::COORD_W+1] ? -diff_x : diff_x;
        init_dy = diff_y[plot_geom_pkg::COORD_W+1] ? diff_y : -diff_y;
    end

    always_comb begin
        e2      = $signed({err, 1'b0});
        err_nxt = err;
        cur_nxt = cur;
        if (e2 >= dy) begin
            err_nxt   = err_nxt + dy;
            cur_nxt.x = sx ? cur.x + 1'b1 : cur.x - 1'b1;
        end
        if (e2 <= dx) begin
            err_nxt   = err_nxt + dx;
            cur_nxt.y = sy ? cur.y + 1'b1 : cur.y - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (seg_fire) begin
                        state <= WALK;
                    end
                end
                WALK: begin
                    if (pix_ready && at_end) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (seg_fire) begin
            cur  <= seg.start_pt;
            last <= seg.end_pt;
            tag  <= seg.tag;
            dx   <= init_dx;
            dy   <= init_dy;
            err  <= init_dx + init_dy;
            sx   <= !diff_x[plot_geom_pkg::COORD_W+1];
            sy   <= !diff_y[plot_geom_pkg::COORD_W+1];
        end else if (pix_valid && pix_ready) begin
            cur <= cur_nxt;
            err <= err_nxt;
        end
    end

endmodule

`default_nettype wire

//--- src/pixel_merge.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_merge (
    input  logic                                clk,
    input  logic                                rst,
    input  plot_geom_pkg::pixel_t               pix [plot_cmd_pkg::N_RASTER],
    input  logic [plot_cmd_pkg::N_RASTER-1:0]   pix_valid,
    output logic [plot_cmd_pkg::N_RASTER-1:0]   pix_ready,
    output plot_geom_pkg::pixel_t               pixel,
    output logic                                pixel_valid,
    input  logic                                pixel_ready
);

    plot_cmd_pkg::raster_idx_t ptr;
    plot_cmd_pkg::raster_idx_t gnt_idx;
    logic                      gnt_found;
    int                        cand;

    // first valid input at or after the pointer wins
    always_comb begin
        gnt_found = 1'b0;
        gnt_idx   = ptr;
        cand      = 0;
        for (int i = 0; i < plot_cmd_pkg::N_RASTER; i++) begin
            cand = int'(ptr) + i;
            if (cand >= plot_cmd_pkg::N_RASTER) begin
                cand = cand - plot_cmd_pkg::N_RASTER;
            end
            if (!gnt_found && pix_valid[cand]) begin
                gnt_idx   = plot_cmd_pkg::raster_idx_t'(cand);
                gnt_found = 1'b1;
            end
        end
    end

    assign pixel       = pix[gnt_idx];
    assign pixel_valid = gnt_found;

    always_comb begin
        for (int k = 0; k < plot_cmd_pkg::N_RASTER; k++) begin
            pix_ready[k] = gnt_found && pixel_ready &&
                           (gnt_idx == plot_cmd_pkg::raster_idx_t'(k));
        end
    end

    // pointer only moves on a completed transfer so a stalled grant sticks
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (pixel_valid && pixel_ready) begin
            if (gnt_idx == plot_cmd_pkg::raster_idx_t'(plot_cmd_pkg::N_RASTER - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= gnt_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/plot_engine.sv
`timescale 1ns/1ps
`default_nettype none

module plot_engine (
    input  logic                  clk,
    input  logic                  rst,
    input  plot_cmd_pkg::cmd_t    cmd,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    output plot_geom_pkg::pixel_t pixel,
    output logic                  pixel_valid,
    input  logic                  pixel_ready,
    output logic                  busy
);

    plot_cmd_pkg::segment_t                   seg;
    logic [plot_cmd_pkg::N_RASTER-1:0]        seg_valid;
    logic [plot_cmd_pkg::N_RASTER-1:0]        seg_ready;
    logic                                     pending;
    plot_geom_pkg::pixel_t                    pix [plot_cmd_pkg::N_RASTER];
    logic [plot_cmd_pkg::N_RASTER-1:0]        pix_valid;
    logic [plot_cmd_pkg::N_RASTER-1:0]        pix_ready;

    // a rasterizer that is not ready is still walking a segment
    assign busy = pending || (|(~seg_ready));

    segment_dispatch segment_dispatch_i (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .seg       (seg),
        .seg_valid (seg_valid),
        .seg_ready (seg_ready),
        .pending   (pending)
    );

    for (genvar k = 0; k < plot_cmd_pkg::N_RASTER; k++) begin : g_raster
        line_raster line_raster_i (
            .clk       (clk),
            .rst       (rst),
            .seg       (seg),
            .seg_valid (seg_valid[k]),
            .seg_ready (seg_ready[k]),
            .pix       (pix[k]),
            .pix_valid (pix_valid[k]),
            .pix_ready (pix_ready[k])
        );
    end

    pixel_merge pixel_merge_i (
        .clk         (clk),
        .rst         (rst),
        .pix         (pix),
        .pix_valid   (pix_valid),
        .pix_ready   (pix_ready),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .pixel_ready (pixel_ready)
    );

endmodule

`default_nettype wire

//--- tb/tb_plot_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_plot_engine;

    localparam int N_CMD = 16;
    localparam int N_TAG = 16;

    typedef struct packed {
        plot_cmd_pkg::opcode_e op;
        plot_geom_pkg::point_t target;
        logic [7:0]            count;
    } entry_t;

    // counts are max(|dx|,|dy|)+1 from the running cursor, zero for MOVE
    localparam entry_t cmd_table [N_CMD] = '{
        '{plot_cmd_pkg::MOVE, '{8'd100, 8'd100}, 8'd0},
        '{plot_cmd_pkg::LINE, '{8'd110, 8'd104}, 8'd11},
        '{plot_cmd_pkg::LINE, '{8'd114, 8'd114}, 8'd11},
        '{plot_cmd_pkg::LINE, '{8'd110, 8'd124}, 8'd11},
        '{plot_cmd_pkg::LINE, '{8'd96,  8'd129}, 8'd15},
        '{plot_cmd_pkg::LINE, '{8'd90,  8'd116}, 8'd14},
        '{plot_cmd_pkg::LINE, '{8'd80,  8'd110}, 8'd11},
        '{plot_cmd_pkg::MOVE, '{8'd50,  8'd50},  8'd0},
        '{plot_cmd_pkg::MOVE, '{8'd60,  8'd60},  8'd0},
        '{plot_cmd_pkg::LINE, '{8'd63,  8'd40},  8'd21},
        '{plot_cmd_pkg::LINE, '{8'd80,  8'd31},  8'd18},
        '{plot_cmd_pkg::LINE, '{8'd80,  8'd45},  8'd15},
        '{plot_cmd_pkg::LINE, '{8'd65,  8'd45},  8'd16},
        '{plot_cmd_pkg::LINE, '{8'd65,  8'd45},  8'd1},
        '{plot_cmd_pkg::LINE, '{8'd75,  8'd55},  8'd11},
        '{plot_cmd_pkg::MOVE, '{8'd0,   8'd0},   8'd0}
    };

    logic                  clk;
    logic                  rst;
    plot_cmd_pkg::cmd_t    cmd;
    logic                  cmd_valid;
    logic                  cmd_ready;
    plot_geom_pkg::pixel_t pixel;
    logic                  pixel_valid;
    logic                  pixel_ready;
    logic                  busy;

    integer                seed = 32'h7d54bad4;
    int                    mismatch_cnt = 0;
    int                    fail_cnt = 0;
    int                    total_got = 0;
    int                    got_cnt [N_TAG];
    int                    exp_cnt [N_TAG];
    plot_geom_pkg::point_t exp_end [N_TAG];
    plot_geom_pkg::point_t exp_q [N_TAG][$];

    plot_engine plot_engine_i (
        .clk         (clk),
        .rst         (rst),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .pixel       (pixel),
        .pixel_valid (pixel_valid),
        .pixel_ready (pixel_ready),
        .busy        (busy)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic int total_pixels();
        int sum;
        sum = 0;
        for (int i = 0; i < N_CMD; i++) begin
            sum += cmd_table[i].count;
        end
        return sum;
    endfunction

    // reference walk of one line, pushed into the queue of its tag
    task automatic build_line(input plot_geom_pkg::point_t p0,
                              input plot_geom_pkg::point_t p1, input int t);
        plot_geom_pkg::point_t pt;
        int x;
        int y;
        int x1;
        int y1;
        int dx;
        int dy;
        int sx;
        int sy;
        int err;
        int e2;
        int n;
        x  = p0.x;
        y  = p0.y;
        x1 = p1.x;
        y1 = p1.y;
        dx = (x1 >= x) ? x1 - x : x - x1;
        dy = (y1 >= y) ? y - y1 : y1 - y;
        sx = (x < x1) ? 1 : -1;
        sy = (y < y1) ? 1 : -1;
        err = dx + dy;
        n = 0;
        forever begin
            pt.x = x[7:0];
            pt.y = y[7:0];
            exp_q[t].push_back(pt);
            n++;
            if (x == x1 && y == y1) begin
                break;
            end
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                x += sx;
            end
            if (e2 <= dx) begin
                err += dx;
                y += sy;
            end
        end
        exp_cnt[t] = n;
        exp_end[t] = p1;
    endtask

    task automatic check_idle(input string phase);
        assert (!pixel_valid && !busy && cmd_ready) else begin
            mismatch_cnt++;
            $display("mismatch at %0t: outputs not idle %s (pixel_valid=%b busy=%b cmd_ready=%b)",
                     $time, phase, pixel_valid, busy, cmd_ready);
        end
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_cmd(input entry_t e);
        cmd.op     = e.op;
        cmd.target = e.target;
        cmd_valid  = 1'b1;
        while (!cmd_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    initial begin
        plot_geom_pkg::point_t ref_cursor;
        int ref_tag;
        rst         = 1'b1;
        cmd         = '0;
        cmd_valid   = 1'b0;
        pixel_ready = 1'b0;
        ref_cursor  = '0;
        ref_tag     = 0;
        @(negedge clk);
        check_idle("during reset");
        @(negedge clk);
        check_idle("during reset");
        rst = 1'b0;
        @(negedge clk);
        check_idle("after reset");

        for (int i = 0; i < N_CMD; i++) begin
            if (cmd_table[i].op == plot_cmd_pkg::LINE) begin
                build_line(ref_cursor, cmd_table[i].target, ref_tag);
                assert (exp_cnt[ref_tag] == cmd_table[i].count) else begin
                    fail_cnt++;
                    $display("table entry %0d lists %0d pixels but the model walks %0d",
                             i, cmd_table[i].count, exp_cnt[ref_tag]);
                end
                ref_tag = (ref_tag + 1) % N_TAG;
            end
            ref_cursor = cmd_table[i].target;
            send_cmd(cmd_table[i]);
            // an accepted LINE is pending or walking, so the engine is busy
            if (cmd_table[i].op == plot_cmd_pkg::LINE) begin
                assert (busy) else begin
                    mismatch_cnt++;
                    $display("mismatch at %0t: busy low right after LINE entry %0d",
                             $time, i);
                end
            end
        end

        while (total_got < total_pixels()) begin
            @(negedge clk);
        end
        // idle a while so stray pixels would still show up
        repeat (20) @(negedge clk);

        assert (!busy) else begin
            mismatch_cnt++;
            $display("mismatch at %0t: busy still high after all pixels arrived", $time);
        end
        for (int t = 0; t < N_TAG; t++) begin
            assert (exp_q[t].size() == 0) else begin
                fail_cnt++;
                $display("tag %0d still waits for %0d pixels", t, exp_q[t].size());
            end
            assert (got_cnt[t] == exp_cnt[t]) else begin
                fail_cnt++;
                $display("tag %0d produced %0d pixels instead of %0d",
                         t, got_cnt[t], exp_cnt[t]);
            end
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // random back-pressure, then look at the pixel that the next edge takes
    initial begin
        plot_geom_pkg::point_t want;
        int t;
        forever begin
            @(negedge clk);
            pixel_ready = ($random(seed) & 3) != 0;
            #1;
            // a pixel on the output means some rasterizer is walking
            assert (!pixel_valid || busy) else begin
                mismatch_cnt++;
                $display("mismatch at %0t: busy low while pixel_valid is high", $time);
            end
            if (pixel_valid && pixel_ready) begin
                t = pixel.tag;
                total_got++;
                got_cnt[t]++;
                assert (exp_q[t].size() != 0) else begin
                    fail_cnt++;
                    $display("%0t: pixel (%0d,%0d) with tag %0d arrived with none expected",
                             $time, pixel.pt.x, pixel.pt.y, t);
                end
                if (exp_q[t].size() != 0) begin
                    want = exp_q[t].pop_front();
                    assert (pixel.pt == want) else begin
                        mismatch_cnt++;
                        $display("mismatch at %0t: tag %0d expected (%0d,%0d) got (%0d,%0d)",
                                 $time, t, want.x, want.y, pixel.pt.x, pixel.pt.y);
                    end
                    if (got_cnt[t] == exp_cnt[t]) begin
                        assert (pixel.pt == exp_end[t]) else begin
                            mismatch_cnt++;
                            $display("mismatch at %0t: tag %0d ends at (%0d,%0d), not (%0d,%0d)",
                                     $time, t, pixel.pt.x, pixel.pt.y,
                                     exp_end[t].x, exp_end[t].y);
                        end
                    end
                end
            end
        end
    end

    // limit scales with the amount of work in the table
    initial begin
        int limit;
        limit = 20 * (total_pixels() + N_CMD) * 10;
        #(limit);
        $display("run timed out after %0d ns before all pixels arrived", limit);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
src/plot_geom_pkg.sv
src/plot_cmd_pkg.sv
src/segment_dispatch.sv
src/line_raster.sv
src/pixel_merge.sv
src/plot_engine.sv
tb/tb_plot_engine.sv

//--- Bender.yml
package:
  name: plot_engine

sources:
  - src/plot_geom_pkg.sv
  - src/plot_cmd_pkg.sv
  - src/segment_dispatch.sv
  - src/line_raster.sv
  - src/pixel_merge.sv
  - src/plot_engine.sv
  - target: test
    files:
      - tb/tb_plot_engine.sv
